// ==== rtl/exe_pkg.sv ====
`default_nettype none

package exe_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [15:0]     imm_t;
  typedef logic [3:0]      strb_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_slt, alu_sltu,
    alu_and, alu_or, alu_xor, alu_nor,
    alu_sll, alu_srl, alu_sra, alu_lui
  } alu_op_e;

  typedef enum logic [1:0] {
    src1_rs, src1_sa, src1_pc
  } src1_sel_e;

  typedef enum logic [1:0] {
    src2_rt, src2_imm_sext, src2_imm_zext, src2_eight
  } src2_sel_e;

  typedef enum logic [3:0] {
    mem_none, mem_lb, mem_lbu, mem_lh, mem_lhu,
    mem_lw, mem_sb, mem_sh, mem_sw
  } mem_op_e;

  typedef enum logic [2:0] {
    hilo_none, hilo_mthi, hilo_mtlo, hilo_mfhi,
    hilo_mflo, hilo_div, hilo_divu
  } hilo_op_e;

  // cp0 cause codes
  typedef enum logic [4:0] {
    excp_none = 5'd0,
    excp_adel = 5'd4,
    excp_ades = 5'd5,
    excp_ov   = 5'd12
  } excp_code_e;

  typedef struct packed {
    word_t     pc;
    alu_op_e   alu_op;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    imm_t      imm;
    word_t     rs_value;
    word_t     rt_value;
    reg_idx_t  dest;
    logic      gr_we;
    mem_op_e   mem_op;
    hilo_op_e  hilo_op;
    logic      ov_en;
  } exe_in_t;

  typedef struct packed {
    word_t      pc;
    word_t      result;
    reg_idx_t   dest;
    logic       gr_we;
    logic       load;
    logic       excp_valid;
    excp_code_e excp_code;
  } exe_out_t;

endpackage

`default_nettype wire

// ==== rtl/exe_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_alu import exe_pkg::*; (
  input  alu_op_e alu_op,
  input  word_t   src1,
  input  word_t   src2,
  output word_t   result,
  output logic    overflow
);

  word_t      sum;
  word_t      diff;
  logic [4:0] shamt;
  logic       lt_signed;

  assign sum   = src1 + src2;
  assign diff  = src1 - src2;
  assign shamt = src1[4:0];

  // differing signs decide directly, else the difference sign does
  assign lt_signed = (src1[XLEN-1] != src2[XLEN-1]) ? src1[XLEN-1] : diff[XLEN-1];

  always_comb begin
    case (alu_op)
      alu_add:  result = sum;
      alu_sub:  result = diff;
      alu_slt:  result = word_t'(lt_signed);
      alu_sltu: result = word_t'(src1 < src2);
      alu_and:  result = src1 & src2;
      alu_or:   result = src1 | src2;
      alu_xor:  result = src1 ^ src2;
      alu_nor:  result = ~(src1 | src2);
      alu_sll:  result = src2 << shamt;
      alu_srl:  result = src2 >> shamt;
      alu_sra:  result = word_t'($signed(src2) >>> shamt);
      alu_lui:  result = {src2[15:0], {(XLEN-16){1'b0}}};
      default:  result = '0;
    endcase
  end

  // signed overflow, add and sub only
  always_comb begin
    case (alu_op)
      alu_add: begin
        overflow = (src1[XLEN-1] == src2[XLEN-1]) && (sum[XLEN-1] != src1[XLEN-1]);
      end
      alu_sub: begin
        overflow = (src1[XLEN-1] != src2[XLEN-1]) && (diff[XLEN-1] != src1[XLEN-1]);
      end
      default: begin
        overflow = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_align import exe_pkg::*; (
  input  mem_op_e    mem_op,
  input  logic [1:0] addr_low,
  input  word_t      rt_value,
  output strb_t      wstrb,
  output word_t      wdata,
  output logic [1:0] size,
  output logic       misaligned
);

  logic is_byte;
  logic is_half;
  logic is_word;
  logic is_store;

  assign is_byte  = mem_op inside {mem_lb, mem_lbu, mem_sb};
  assign is_half  = mem_op inside {mem_lh, mem_lhu, mem_sh};
  assign is_word  = mem_op inside {mem_lw, mem_sw};
  assign is_store = mem_op inside {mem_sb, mem_sh, mem_sw};

  always_comb begin
    if (is_byte) begin
      size  = 2'd0;
      wdata = {4{rt_value[7:0]}};
      wstrb = strb_t'(4'b0001 << addr_low);
    end else if (is_half) begin
      size  = 2'd1;
      wdata = {2{rt_value[15:0]}};
      wstrb = addr_low[1] ? 4'b1100 : 4'b0011;
    end else begin
      size  = 2'd2;
      wdata = rt_value;
      wstrb = 4'b1111;
    end
    // loads write no lanes
    if (!is_store) begin
      wstrb = '0;
    end
  end

  assign misaligned = (is_half && addr_low[0]) || (is_word && addr_low != 2'b00);

endmodule

`default_nettype wire

// ==== rtl/serial_div.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_div #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic             is_signed,
  input  logic [WIDTH-1:0] dividend,
  input  logic [WIDTH-1:0] divisor,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder,
  output logic             done
);

  localparam int CNT_W = $clog2(WIDTH + 1);

  typedef enum logic [1:0] {
    div_idle,
    div_run,
    div_done
  } div_state_e;

  div_state_e       state;
  logic [CNT_W-1:0] count;
  logic [WIDTH-1:0] quo;
  logic [WIDTH-1:0] rem;
  logic [WIDTH-1:0] dvs;
  logic             neg_q;
  logic             neg_r;
  logic             dvd_neg;
  logic             dvs_neg;
  logic [WIDTH:0]   shifted;
  logic [WIDTH:0]   trial;

  assign dvd_neg = is_signed && dividend[WIDTH-1];
  assign dvs_neg = is_signed && divisor[WIDTH-1];

  // partial remainder with the next dividend bit shifted in
  assign shifted = {rem, quo[WIDTH-1]};
  assign trial   = shifted - {1'b0, dvs};

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= div_idle;
      count <= '0;
    end else begin
      case (state)
        div_run: begin
          count <= count + 1'b1;
          if (count == CNT_W'(WIDTH - 1)) begin
            state <= div_done;
          end
        end
        default: begin
          if (start) begin
            state <= div_run;
            count <= '0;
          end
        end
      endcase
    end
  end

  // a zero divisor never restores, so quotient ends all ones
  // and the remainder ends as the dividend magnitude
  always_ff @(posedge clk) begin
    if (start && state != div_run) begin
      quo   <= dvd_neg ? -dividend : dividend;
      dvs   <= dvs_neg ? -divisor : divisor;
      rem   <= '0;
      neg_q <= dvd_neg ^ dvs_neg;
      neg_r <= dvd_neg;
    end else if (state == div_run) begin
      if (!trial[WIDTH]) begin
        rem <= trial[WIDTH-1:0];
        quo <= {quo[WIDTH-2:0], 1'b1};
      end else begin
        rem <= shifted[WIDTH-1:0];
        quo <= {quo[WIDTH-2:0], 1'b0};
      end
    end
  end

  assign quotient  = neg_q ? -quo : quo;
  assign remainder = neg_r ? -rem : rem;
  assign done      = (state == div_done);

  assert property (@(posedge clk) disable iff (reset) start |-> state != div_run);

endmodule

`default_nettype wire

// ==== rtl/hi_lo_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module hi_lo_regs import exe_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     we,
  input  hilo_op_e hilo_op,
  input  word_t    rs_value,
  input  word_t    div_quotient,
  input  word_t    div_remainder,
  output word_t    rd_value
);

  word_t hi;
  word_t lo;

  always_ff @(posedge clk) begin
    if (reset) begin
      hi <= '0;
      lo <= '0;
    end else if (we) begin
      case (hilo_op)
        hilo_mthi: hi <= rs_value;
        hilo_mtlo: lo <= rs_value;
        // quotient to lo, remainder to hi
        hilo_div, hilo_divu: begin
          lo <= div_quotient;
          hi <= div_remainder;
        end
        default: begin
        end
      endcase
    end
  end

  assign rd_value = (hilo_op == hilo_mfhi) ? hi : lo;

endmodule

`default_nettype wire

// ==== rtl/data_req_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_req_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic active,
  input  logic is_store,
  input  logic ms_allowin,
  input  logic addr_ok,
  input  logic data_ok,
  input  logic leave,
  output logic req,
  output logic complete
);

  logic issued;
  logic waiting;
  logic taken;

  // before issue, waiting holds a request that is out on the bus;
  // after a store issues, it marks data_ok still due
  assign req   = active && !issued && (ms_allowin || waiting);
  assign taken = req && addr_ok;

  // data_ok comes at least one cycle after its addr_ok
  assign complete = is_store ? (issued && (!waiting || data_ok)) : (taken || issued);

  always_ff @(posedge clk) begin
    if (reset || leave) begin
      issued  <= 1'b0;
      waiting <= 1'b0;
    end else if (taken) begin
      issued  <= 1'b1;
      waiting <= is_store;
    end else if (req) begin
      waiting <= 1'b1;
    end else if (issued && data_ok) begin
      waiting <= 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (reset) req && !addr_ok |=> req);

endmodule

`default_nettype wire

// ==== rtl/exe_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_stage import exe_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       in_valid,
  input  exe_in_t    in_bus,
  output logic       in_allowin,
  output logic       out_valid,
  output exe_out_t   out_bus,
  input  logic       ms_allowin,
  output logic       data_req,
  output logic       data_wr,
  output logic [1:0] data_size,
  output strb_t      data_wstrb,
  output word_t      data_addr,
  output word_t      data_wdata,
  input  logic       data_addr_ok,
  input  logic       data_data_ok
);

  logic       valid;
  exe_in_t    es;
  logic       ready_go;
  logic       leave;
  word_t      src1;
  word_t      src2;
  word_t      alu_result;
  logic       alu_ov;
  logic       overflow;
  logic       is_load;
  logic       is_store;
  logic       is_div;
  logic       misaligned;
  logic       mem_active;
  logic       mem_complete;
  logic       div_start;
  logic       div_done;
  word_t      div_quotient;
  word_t      div_remainder;
  word_t      hilo_value;
  logic       excp_valid;
  excp_code_e excp_code;
  logic       addr_seen;
  logic       data_seen;

  assign is_load  = es.mem_op inside {mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw};
  assign is_store = es.mem_op inside {mem_sb, mem_sh, mem_sw};
  assign is_div   = es.hilo_op inside {hilo_div, hilo_divu};

  // done still shows the previous division while div_start is high
  assign ready_go   = (!is_div || (div_done && !div_start)) && (!mem_active || mem_complete);
  assign in_allowin = !valid || (ready_go && ms_allowin);
  assign out_valid  = valid && ready_go;
  assign leave      = out_valid && ms_allowin;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid     <= 1'b0;
      div_start <= 1'b0;
    end else begin
      if (in_allowin) begin
        valid <= in_valid;
      end
      div_start <= in_valid && in_allowin && (in_bus.hilo_op inside {hilo_div, hilo_divu});
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_allowin) begin
      es <= in_bus;
    end
  end

  always_comb begin
    case (es.src1_sel)
      src1_sa: src1 = word_t'(es.imm[10:6]);
      src1_pc: src1 = es.pc;
      default: src1 = es.rs_value;
    endcase
  end

  always_comb begin
    case (es.src2_sel)
      src2_imm_sext: src2 = {{(XLEN-16){es.imm[15]}}, es.imm};
      src2_imm_zext: src2 = {{(XLEN-16){1'b0}}, es.imm};
      src2_eight:    src2 = word_t'(8);
      default:       src2 = es.rt_value;
    endcase
  end

  exe_alu exe_alu_inst (
    .alu_op   (es.alu_op),
    .src1     (src1),
    .src2     (src2),
    .result   (alu_result),
    .overflow (alu_ov)
  );

  store_align store_align_inst (
    .mem_op     (es.mem_op),
    .addr_low   (alu_result[1:0]),
    .rt_value   (es.rt_value),
    .wstrb      (data_wstrb),
    .wdata      (data_wdata),
    .size       (data_size),
    .misaligned (misaligned)
  );

  assign overflow   = es.ov_en && alu_ov;
  assign mem_active = valid && (is_load || is_store) && !misaligned && !overflow;

  // overflow first, then adel, then ades
  always_comb begin
    excp_valid = 1'b1;
    if (overflow) begin
      excp_code = excp_ov;
    end else if (is_load && misaligned) begin
      excp_code = excp_adel;
    end else if (is_store && misaligned) begin
      excp_code = excp_ades;
    end else begin
      excp_valid = 1'b0;
      excp_code  = excp_none;
    end
  end

  data_req_ctrl data_req_ctrl_inst (
    .clk        (clk),
    .reset      (reset),
    .active     (mem_active),
    .is_store   (is_store),
    .ms_allowin (ms_allowin),
    .addr_ok    (data_addr_ok),
    .data_ok    (data_data_ok),
    .leave      (leave),
    .req        (data_req),
    .complete   (mem_complete)
  );

  assign data_wr   = is_store;
  assign data_addr = alu_result;

  serial_div #(
    .WIDTH (XLEN)
  ) serial_div_inst (
    .clk       (clk),
    .reset     (reset),
    .start     (div_start),
    .is_signed (es.hilo_op == hilo_div),
    .dividend  (es.rs_value),
    .divisor   (es.rt_value),
    .quotient  (div_quotient),
    .remainder (div_remainder),
    .done      (div_done)
  );

  hi_lo_regs hi_lo_regs_inst (
    .clk           (clk),
    .reset         (reset),
    .we            (leave && !excp_valid),
    .hilo_op       (es.hilo_op),
    .rs_value      (es.rs_value),
    .div_quotient  (div_quotient),
    .div_remainder (div_remainder),
    .rd_value      (hilo_value)
  );

  always_comb begin
    out_bus.pc         = es.pc;
    out_bus.result     = (es.hilo_op inside {hilo_mfhi, hilo_mflo}) ? hilo_value : alu_result;
    out_bus.dest       = es.dest;
    out_bus.gr_we      = es.gr_we;
    out_bus.load       = is_load;
    out_bus.excp_valid = excp_valid;
    out_bus.excp_code  = excp_code;
  end

  // access progress as seen on the port, cleared when the item leaves
  always_ff @(posedge clk) begin
    if (reset || leave) begin
      addr_seen <= 1'b0;
      data_seen <= 1'b0;
    end else begin
      if (data_req && data_addr_ok) begin
        addr_seen <= 1'b1;
      end
      if (addr_seen && data_data_ok) begin
        data_seen <= 1'b1;
      end
    end
  end

  // memory item shows out_valid only once its access has completed
  assert property (@(posedge clk) disable iff (reset)
    mem_active && out_valid |->
      (is_store ? (data_seen || (addr_seen && data_data_ok))
                : (addr_seen || (data_req && data_addr_ok))));

endmodule

`default_nettype wire

// ==== bench/exe_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_stage_tb import exe_pkg::*; ();

  localparam int WAIT_LIMIT = 200;
  localparam int RANDOM_ITEMS = 600;

  typedef struct packed {
    exe_out_t   bus;
    logic       mem_req;
    logic       wr;
    logic [1:0] size;
    strb_t      wstrb;
    word_t      wdata;
    logic       plain;
  } expect_t;

  logic       clk;
  logic       reset;
  logic       in_valid;
  exe_in_t    in_bus;
  logic       in_allowin;
  logic       out_valid;
  exe_out_t   out_bus;
  logic       ms_allowin;
  logic       data_req;
  logic       data_wr;
  logic [1:0] data_size;
  strb_t      data_wstrb;
  word_t      data_addr;
  word_t      data_wdata;
  logic       data_addr_ok;
  logic       data_data_ok;

  integer   seed = 80913;
  // responder draws from its own stream
  integer   resp_seed = 80913 * 3;
  expect_t  expq [$];
  word_t    model_hi = '0;
  word_t    model_lo = '0;
  int       taken_cnt = 0;
  int       dok_cnt = 0;
  logic     store_pend = 1'b0;
  logic     held = 1'b0;
  logic     req_hold = 1'b0;
  exe_out_t held_bus;

  mem_op_e  odd_ops [0:4] = '{mem_lh, mem_lhu, mem_lw, mem_sh, mem_sw};
  word_t    div_a [0:7] = '{32'd7, 32'hfffffff9, 32'd7, 32'hfffffff9,
                            32'h80000000, 32'd5, 32'hfffffffb, 32'd0};
  word_t    div_b [0:7] = '{32'd2, 32'd2, 32'hfffffffe, 32'hfffffffe,
                            32'hffffffff, 32'd0, 32'd0, 32'd3};

  exe_stage exe_stage_inst (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_bus       (in_bus),
    .in_allowin   (in_allowin),
    .out_valid    (out_valid),
    .out_bus      (out_bus),
    .ms_allowin   (ms_allowin),
    .data_req     (data_req),
    .data_wr      (data_wr),
    .data_size    (data_size),
    .data_wstrb   (data_wstrb),
    .data_addr    (data_addr),
    .data_wdata   (data_wdata),
    .data_addr_ok (data_addr_ok),
    .data_data_ok (data_data_ok)
  );

  always #10 clk = ~clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [95:0] got,
                             input logic [95:0] want);
    if (got !== want) begin
      stop_with_failure($sformatf("[FAIL] %s got 0x%0h expected 0x%0h at %0t",
                                  name, got, want, $time));
    end
  endtask

  function automatic word_t rand_word();
    return word_t'($random(seed));
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic exe_in_t random_item(input int kind);
    exe_in_t    it;
    word_t      sum;
    logic [1:0] want;
    it.pc       = rand_word() & ~word_t'(3);
    it.alu_op   = alu_op_e'(rand_below(12));
    it.src1_sel = src1_sel_e'(rand_below(3));
    it.src2_sel = src2_sel_e'(rand_below(4));
    it.imm      = imm_t'(rand_word());
    it.rs_value = rand_word();
    it.rt_value = rand_word();
    it.dest     = reg_idx_t'(rand_below(32));
    it.gr_we    = rand_below(2) == 1;
    it.mem_op   = mem_none;
    it.hilo_op  = hilo_none;
    it.ov_en    = 1'b0;
    case (kind)
      0: begin
        it.ov_en = rand_below(2) == 1;
        // register add/sub with the trap on, overflow is likely
        if (rand_below(3) == 0) begin
          it.alu_op   = alu_op_e'(rand_below(2));
          it.src1_sel = src1_rs;
          it.src2_sel = src2_rt;
          it.ov_en    = 1'b1;
        end
      end
      1, 2: begin
        it.alu_op   = alu_add;
        it.src1_sel = src1_rs;
        it.src2_sel = src2_imm_sext;
        it.ov_en    = rand_below(2) == 1;
        it.mem_op   = (kind == 1) ? mem_op_e'(1 + rand_below(8)) : odd_ops[rand_below(5)];
        if (it.mem_op inside {mem_lh, mem_lhu, mem_sh}) begin
          want = (kind == 1) ? 2'(2 * rand_below(2)) : 2'(2 * rand_below(2) + 1);
        end else if (it.mem_op inside {mem_lw, mem_sw}) begin
          want = (kind == 1) ? 2'd0 : 2'(1 + rand_below(3));
        end else begin
          want = 2'(rand_below(4));
        end
        // steer the low address bits to the wanted offset
        sum = it.rs_value + {{16{it.imm[15]}}, it.imm};
        it.rs_value = it.rs_value - word_t'(sum[1:0]) + word_t'(want);
      end
      3: begin
        it.hilo_op = (rand_below(2) == 1) ? hilo_div : hilo_divu;
        if (rand_below(6) == 0) begin
          it.rt_value = '0;
        end else begin
          it.rt_value = word_t'($signed(rand_word()) >>> rand_below(31));
        end
      end
      4: begin
        it.hilo_op = (rand_below(2) == 1) ? hilo_mthi : hilo_mtlo;
        // a trapping add makes some moves drop their write
        if (rand_below(3) == 0) begin
          it.alu_op   = alu_add;
          it.src1_sel = src1_rs;
          it.src2_sel = src2_rt;
          it.ov_en    = 1'b1;
        end
      end
      5: it.hilo_op = (rand_below(2) == 1) ? hilo_mfhi : hilo_mflo;
      default: begin
      end
    endcase
    return it;
  endfunction

  // reference model, applied in acceptance order
  task automatic model_item(input exe_in_t it, output expect_t e);
    word_t       s1;
    word_t       s2;
    word_t       res;
    word_t       a_mag;
    word_t       b_mag;
    word_t       q_mag;
    word_t       r_mag;
    logic [XLEN:0] wide;
    logic        ov;
    logic        is_ld;
    logic        is_st;
    logic        is_half;
    logic        is_word;
    logic        mis;
    logic        a_neg;
    logic        b_neg;
    e  = '0;
    ov = 1'b0;
    case (it.src1_sel)
      src1_sa: s1 = {27'd0, it.imm[10:6]};
      src1_pc: s1 = it.pc;
      default: s1 = it.rs_value;
    endcase
    case (it.src2_sel)
      src2_imm_sext: s2 = {{16{it.imm[15]}}, it.imm};
      src2_imm_zext: s2 = {16'd0, it.imm};
      src2_eight:    s2 = 32'd8;
      default:       s2 = it.rt_value;
    endcase
    case (it.alu_op)
      alu_add, alu_sub: begin
        if (it.alu_op == alu_add) begin
          wide = {s1[XLEN-1], s1} + {s2[XLEN-1], s2};
        end else begin
          wide = {s1[XLEN-1], s1} - {s2[XLEN-1], s2};
        end
        res = wide[XLEN-1:0];
        ov  = wide[XLEN] != wide[XLEN-1];
      end
      alu_slt:  res = ($signed(s1) < $signed(s2)) ? 32'd1 : 32'd0;
      alu_sltu: res = (s1 < s2) ? 32'd1 : 32'd0;
      alu_and:  res = s1 & s2;
      alu_or:   res = s1 | s2;
      alu_xor:  res = s1 ^ s2;
      alu_nor:  res = ~(s1 | s2);
      alu_sll:  res = s2 << s1[4:0];
      alu_srl:  res = s2 >> s1[4:0];
      alu_sra:  res = $signed(s2) >>> s1[4:0];
      alu_lui:  res = {s2[15:0], 16'd0};
      default:  res = '0;
    endcase
    is_ld   = it.mem_op inside {mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw};
    is_st   = it.mem_op inside {mem_sb, mem_sh, mem_sw};
    is_half = it.mem_op inside {mem_lh, mem_lhu, mem_sh};
    is_word = it.mem_op inside {mem_lw, mem_sw};
    mis     = (is_half && res[0]) || (is_word && res[1:0] != 2'd0);
    e.size  = is_word ? 2'd2 : (is_half ? 2'd1 : 2'd0);
    if (is_word) begin
      e.wstrb = 4'b1111;
      e.wdata = it.rt_value;
    end else if (is_half) begin
      e.wstrb = res[1] ? 4'b1100 : 4'b0011;
      e.wdata = {it.rt_value[15:0], it.rt_value[15:0]};
    end else begin
      for (int lane = 0; lane < 4; lane++) begin
        e.wstrb[lane] = (lane == int'(res[1:0]));
      end
      e.wdata = {4{it.rt_value[7:0]}};
    end
    if (!is_st) begin
      e.wstrb = '0;
    end
    e.bus.pc         = it.pc;
    e.bus.dest       = it.dest;
    e.bus.gr_we      = it.gr_we;
    e.bus.load       = is_ld;
    e.bus.excp_valid = 1'b1;
    if (it.ov_en && ov) begin
      e.bus.excp_code = excp_ov;
    end else if (is_ld && mis) begin
      e.bus.excp_code = excp_adel;
    end else if (is_st && mis) begin
      e.bus.excp_code = excp_ades;
    end else begin
      e.bus.excp_valid = 1'b0;
      e.bus.excp_code  = excp_none;
    end
    if (it.hilo_op == hilo_mfhi) begin
      e.bus.result = model_hi;
    end else if (it.hilo_op == hilo_mflo) begin
      e.bus.result = model_lo;
    end else begin
      e.bus.result = res;
    end
    e.mem_req = (is_ld || is_st) && !e.bus.excp_valid;
    e.wr      = is_st;
    e.plain   = !e.mem_req && !(it.hilo_op inside {hilo_div, hilo_divu});
    if (!e.bus.excp_valid) begin
      case (it.hilo_op)
        hilo_mthi: model_hi = it.rs_value;
        hilo_mtlo: model_lo = it.rs_value;
        hilo_div, hilo_divu: begin
          a_neg = (it.hilo_op == hilo_div) && it.rs_value[XLEN-1];
          b_neg = (it.hilo_op == hilo_div) && it.rt_value[XLEN-1];
          a_mag = a_neg ? -it.rs_value : it.rs_value;
          b_mag = b_neg ? -it.rt_value : it.rt_value;
          if (b_mag == '0) begin
            q_mag = '1;
            r_mag = a_mag;
          end else begin
            q_mag = a_mag / b_mag;
            r_mag = a_mag % b_mag;
          end
          model_lo = (a_neg ^ b_neg) ? -q_mag : q_mag;
          model_hi = a_neg ? -r_mag : r_mag;
        end
        default: begin
        end
      endcase
    end
  endtask

  task automatic send_item(input exe_in_t item);
    int waited;
    in_valid <= 1'b1;
    in_bus   <= item;
    waited = 0;
    @(negedge clk);
    while (!in_allowin) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        stop_with_failure("timed out waiting for the stage to accept an item");
      end
      @(negedge clk);
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic run_div_check(input word_t a, input word_t b, input hilo_op_e op);
    exe_in_t item;
    item = random_item(3);
    item.rs_value = a;
    item.rt_value = b;
    item.hilo_op  = op;
    send_item(item);
    item = random_item(5);
    item.hilo_op = hilo_mflo;
    send_item(item);
    item.hilo_op = hilo_mfhi;
    send_item(item);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (expq.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        stop_with_failure("timed out waiting for the stage to drain");
      end
    end
  endtask

  // memory responder and next-stage back-pressure
  always @(posedge clk) begin
    if (!reset) begin
      ms_allowin   <= ($unsigned($random(resp_seed)) % 4) != 0;
      data_addr_ok <= ($unsigned($random(resp_seed)) % 3) == 0;
      data_data_ok <= store_pend && (($unsigned($random(resp_seed)) % 2) == 0);
    end
  end

  always @(negedge clk) begin
    expect_t h;
    expect_t e;
    logic    full;
    logic    taken_now;
    if (!reset) begin
      full      = expq.size() > 0;
      h         = full ? expq[0] : '0;
      taken_now = data_req && data_addr_ok;
      if (held) begin
        check_value("out_valid", out_valid, 1'b1);
        check_value("out_bus", out_bus, held_bus);
      end
      if (req_hold) begin
        check_value("data_req", data_req, 1'b1);
      end
      if (!full) begin
        check_value("out_valid", out_valid, 1'b0);
        check_value("in_allowin", in_allowin, 1'b1);
        check_value("data_req", data_req, 1'b0);
      end else begin
        check_value("in_allowin", in_allowin, out_valid && ms_allowin);
        if (h.plain) begin
          check_value("out_valid", out_valid, 1'b1);
        end
        if (h.mem_req && h.wr) begin
          check_value("out_valid", out_valid, dok_cnt != 0 || data_data_ok);
        end else if (h.mem_req) begin
          check_value("out_valid", out_valid, taken_cnt != 0 || taken_now);
        end
        if (data_req) begin
          if (!h.mem_req) begin
            stop_with_failure("data_req raised by an item that must not access memory");
          end
          if (taken_cnt != 0) begin
            stop_with_failure("a second data_req was issued for one item");
          end
          check_value("data_addr", data_addr, h.bus.result);
          check_value("data_wr", data_wr, h.wr);
          check_value("data_size", data_size, h.size);
          check_value("data_wstrb", data_wstrb, h.wstrb);
          if (h.wr) begin
            check_value("data_wdata", data_wdata, h.wdata);
          end
        end
      end
      if (taken_now) begin
        taken_cnt++;
      end
      if (data_data_ok) begin
        dok_cnt++;
        store_pend = 1'b0;
      end
      if (taken_now && data_wr) begin
        store_pend = 1'b1;
      end
      if (out_valid && ms_allowin) begin
        check_value("out_bus.pc", out_bus.pc, h.bus.pc);
        check_value("out_bus.result", out_bus.result, h.bus.result);
        check_value("out_bus.dest", out_bus.dest, h.bus.dest);
        check_value("out_bus.gr_we", out_bus.gr_we, h.bus.gr_we);
        check_value("out_bus.load", out_bus.load, h.bus.load);
        check_value("out_bus.excp_valid", out_bus.excp_valid, h.bus.excp_valid);
        check_value("out_bus.excp_code", out_bus.excp_code, h.bus.excp_code);
        check_value("data request count", taken_cnt, h.mem_req);
        h = expq.pop_front();
        taken_cnt = 0;
        dok_cnt   = 0;
      end
      held     = out_valid && !ms_allowin;
      held_bus = out_bus;
      req_hold = data_req && !data_addr_ok;
      if (in_valid && in_allowin) begin
        model_item(in_bus, e);
        expq.push_back(e);
      end
    end
  end

  initial begin
    exe_in_t item;
    int      i;
    clk          = 1'b0;
    reset        = 1'b1;
    in_valid     = 1'b0;
    in_bus       = '0;
    ms_allowin   = 1'b1;
    data_addr_ok = 1'b0;
    data_data_ok = 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("out_valid", out_valid, 1'b0);
    check_value("data_req", data_req, 1'b0);
    check_value("in_allowin", in_allowin, 1'b1);
    @(posedge clk);

    // moves to and from hi/lo
    item = random_item(4);
    item.ov_en = 1'b0;
    item.hilo_op = hilo_mthi;
    send_item(item);
    item.hilo_op = hilo_mtlo;
    item.rs_value = rand_word();
    send_item(item);
    item = random_item(5);
    item.hilo_op = hilo_mfhi;
    send_item(item);
    item.hilo_op = hilo_mflo;
    send_item(item);

    // divide corners, then read back lo and hi
    for (i = 0; i < 8; i++) begin
      run_div_check(div_a[i], div_b[i], hilo_div);
      run_div_check(div_a[i], div_b[i], hilo_divu);
    end

    for (i = 0; i < 12; i++) begin
      send_item(random_item(2));
    end

    for (i = 0; i < RANDOM_ITEMS; i++) begin
      case (rand_below(16))
        0, 1, 2, 3, 4, 5: send_item(random_item(0));
        6, 7, 8, 9:       send_item(random_item(1));
        10:               send_item(random_item(2));
        11, 12:           send_item(random_item(3));
        13:               send_item(random_item(4));
        default:          send_item(random_item(5));
      endcase
      if (rand_below(4) == 0) begin
        @(posedge clk);
      end
    end

    wait_drained();
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== exe_stage.f ====
rtl/exe_pkg.sv
rtl/exe_alu.sv
rtl/store_align.sv
rtl/serial_div.sv
rtl/hi_lo_regs.sv
rtl/data_req_ctrl.sv
rtl/exe_stage.sv
bench/exe_stage_tb.sv
